//--- dv/tb_output_block.sv
`default_nettype none

module tb_output_block import noc_pkg::*;;

  localparam int MAX_FLITS = 128;
  localparam int FLIT_BITS = FLIT_TYPE_WIDTH + PAYLOAD_WIDTH;

  logic                     clk = 1'b0;
  logic                     i_reset;
  logic                     in_valid[PORTS];
  flit_type_e               in_type[PORTS];
  logic [PAYLOAD_WIDTH-1:0] in_payload[PORTS];
  logic                     in_ready[PORTS];
  logic                     out_valid;
  flit_type_e               out_type;
  logic [PAYLOAD_WIDTH-1:0] out_payload;
  logic                     out_ready;

  integer seed = 32'h019a468d;

  // per source stimulus, {type, payload}
  logic [FLIT_BITS-1:0] src_mem[PORTS][MAX_FLITS];
  int                   src_count[PORTS];
  int                   src_pos[PORTS];
  int                   src_seq[PORTS];
  int                   gen_count;

  // reference model state
  bit                   model_busy;
  int                   model_owner;
  int                   model_last;
  logic [FLIT_BITS-1:0] exp_q[$];
  int                   owner_q[$];
  int                   pkt_log[$];

  // output monitor state
  bit                   in_packet;
  int                   pkt_src;
  bit                   hold_pending;
  logic [FLIT_BITS-1:0] hold_flit;
  int                   out_count;

  bit                   traffic_on;
  bit                   gaps_on;
  bit                   ready_random;
  int                   errors;
  int                   tests_run;
  int                   tests_failed;
  int                   test_err_base;
  string                test_name;
  int                   cycle;
  int                   wd_deadline;
  bit                   wd_armed;

  output_block dut0 (
    .clk             (clk        ),
    .i_reset         (i_reset    ),
    .i_in_valid      (in_valid   ),
    .i_in_flit_type  (in_type    ),
    .i_in_payload    (in_payload ),
    .o_in_ready      (in_ready   ),
    .o_out_valid     (out_valid  ),
    .o_out_flit_type (out_type   ),
    .o_out_payload   (out_payload),
    .i_out_ready     (out_ready  )
  );

  always #5 clk = ~clk;

  function automatic bit opens_packet(flit_type_e kind);
    return kind == FLIT_HEAD || kind == FLIT_HEAD_TAIL;
  endfunction

  function automatic bit closes_packet(flit_type_e kind);
    return kind == FLIT_TAIL || kind == FLIT_HEAD_TAIL;
  endfunction

  task automatic flag_error(input string msg);
    $display("error %0t: %s", $time, msg);
    errors++;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model and monitors
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // predicts the owner of the link and the flits it sends out
  task automatic track_inputs();
    int winner;
    int cand;
    if (model_busy) begin
      for (int i = 0; i < PORTS; i++) begin
        if (i != model_owner && in_ready[i] !== 1'b0)
          flag_error($sformatf("o_in_ready[%0d] high while port %0d owns the link",
                               i, model_owner));
      end
      if (in_valid[model_owner] && in_ready[model_owner]) begin
        exp_q.push_back({in_type[model_owner], in_payload[model_owner]});
        if (closes_packet(in_type[model_owner]))
          model_busy = 1'b0;
      end
    end else begin
      for (int i = 0; i < PORTS; i++) begin
        if (in_ready[i] !== 1'b0)
          flag_error($sformatf("o_in_ready[%0d] high with the link free", i));
      end
      winner = -1;
      for (int off = 1; off <= PORTS; off++) begin
        cand = (model_last + off) % PORTS;
        if (winner < 0 && in_valid[cand] && opens_packet(in_type[cand]))
          winner = cand;
      end
      if (winner >= 0) begin
        model_busy  = 1'b1;
        model_owner = winner;
        model_last  = winner;
        owner_q.push_back(winner);
      end
    end
  endtask

  task automatic track_output();
    logic [FLIT_BITS-1:0] got;
    logic [FLIT_BITS-1:0] want;
    int                   src;
    int                   owner;
    got = {out_type, out_payload};
    if (hold_pending && (out_valid !== 1'b1 || got !== hold_flit))
      flag_error($sformatf("output flit changed while stalled, %h to %h", hold_flit, got));
    hold_pending = out_valid && !out_ready;
    hold_flit    = got;
    if (out_valid && out_ready) begin
      out_count++;
      src = int'(out_payload[PAYLOAD_WIDTH-1 -: PORT_ID_WIDTH]);
      if (exp_q.size() == 0) begin
        flag_error($sformatf("output flit %h with none expected", got));
      end else begin
        want = exp_q.pop_front();
        if (got !== want)
          flag_error($sformatf("output flit %h, expected %h", got, want));
      end
      if (opens_packet(out_type)) begin
        if (in_packet)
          flag_error("head flit inside an open packet");
        in_packet = 1'b1;
        pkt_src   = src;
      end else begin
        if (!in_packet)
          flag_error("body or tail flit outside a packet");
        if (src != pkt_src)
          flag_error($sformatf("flit of port %0d inside packet of port %0d", src, pkt_src));
      end
      if (closes_packet(out_type)) begin
        in_packet = 1'b0;
        pkt_log.push_back(pkt_src);
        if (owner_q.size() == 0) begin
          flag_error("packet ended with no grant predicted");
        end else begin
          owner = owner_q.pop_front();
          if (owner != pkt_src)
            flag_error($sformatf("packet from port %0d, expected port %0d", pkt_src, owner));
        end
      end
    end
  endtask

  task automatic drive_sources();
    int pos;
    bit hold;
    for (int i = 0; i < PORTS; i++) begin
      if (in_valid[i] && in_ready[i])
        src_pos[i]++;
      pos  = src_pos[i];
      // a stalled flit stays on the wires
      hold = in_valid[i] && !in_ready[i];
      if (!hold) begin
        if (traffic_on && pos < src_count[i] &&
            (!gaps_on || $unsigned($random(seed)) % 4 != 0)) begin
          in_valid[i]   <= 1'b1;
          in_type[i]    <= flit_type_e'(src_mem[i][pos][PAYLOAD_WIDTH +: FLIT_TYPE_WIDTH]);
          in_payload[i] <= src_mem[i][pos][PAYLOAD_WIDTH-1:0];
        end else begin
          in_valid[i] <= 1'b0;
        end
      end
    end
  endtask

  always @(posedge clk) begin : tb_cycle
    if (i_reset) begin
      model_busy   = 1'b0;
      model_last   = PORTS - 1;
      in_packet    = 1'b0;
      hold_pending = 1'b0;
      exp_q.delete();
      owner_q.delete();
    end else begin
      track_inputs();
      track_output();
    end
    drive_sources();
    out_ready <= ready_random ? ($unsigned($random(seed)) % 2 == 1) : 1'b1;
  end

  always @(posedge clk) begin : watchdog
    cycle++;
    if (wd_armed && cycle > wd_deadline) begin
      $display("timeout: test %s did not drain its traffic in time", test_name);
      $display("Done: errors found");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test steps
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_idle(input string where);
    if (out_valid !== 1'b0)
      flag_error($sformatf("o_out_valid not low %s", where));
    for (int i = 0; i < PORTS; i++) begin
      if (in_ready[i] !== 1'b0)
        flag_error($sformatf("o_in_ready[%0d] not low %s", i, where));
    end
  endtask

  task automatic apply_reset(input bit check);
    @(posedge clk);
    i_reset <= 1'b1;
    repeat (2) begin
      @(posedge clk);
      @(negedge clk);
      if (check) check_idle("during reset");
    end
    @(posedge clk);
    i_reset <= 1'b0;
    @(negedge clk);
    if (check) check_idle("during reset");
    @(posedge clk);
    @(negedge clk);
    if (check) check_idle("after reset");
  endtask

  // packets of 1 to 6 flits, payload is {port, sequence}
  task automatic load_packets(input int port, input int n_packets, input int single_pct);
    int                       len;
    flit_type_e               kind;
    logic [PAYLOAD_WIDTH-1:0] payload;
    for (int p = 0; p < n_packets; p++) begin
      len = 1 + $unsigned($random(seed)) % 6;
      if ($unsigned($random(seed)) % 100 < single_pct)
        len = 1;
      for (int f = 0; f < len; f++) begin
        if (len == 1)
          kind = FLIT_HEAD_TAIL;
        else if (f == 0)
          kind = FLIT_HEAD;
        else if (f == len - 1)
          kind = FLIT_TAIL;
        else
          kind = FLIT_BODY;
        payload = PAYLOAD_WIDTH'(src_seq[port]);
        payload[PAYLOAD_WIDTH-1 -: PORT_ID_WIDTH] = PORT_ID_WIDTH'(port);
        src_seq[port]++;
        src_mem[port][src_count[port]] = {kind, payload};
        src_count[port]++;
        gen_count++;
      end
    end
  endtask

  function automatic bit traffic_drained();
    for (int i = 0; i < PORTS; i++) begin
      if (src_pos[i] < src_count[i])
        return 1'b0;
    end
    return exp_q.size() == 0 && !out_valid;
  endfunction

  task automatic run_traffic(input bit gaps, input bit random_ready);
    @(negedge clk);
    out_count    = 0;
    wd_deadline  = cycle + 20 * gen_count + 200;
    wd_armed     = 1'b1;
    gaps_on      = gaps;
    ready_random = random_ready;
    traffic_on   = 1'b1;
    while (!traffic_drained())
      @(negedge clk);
    traffic_on   = 1'b0;
    ready_random = 1'b0;
    wd_armed     = 1'b0;
    if (out_count != gen_count)
      flag_error($sformatf("%0d flits out, %0d generated", out_count, gen_count));
    if (in_packet)
      flag_error("output packet left open");
    if (owner_q.size() != 0)
      flag_error("predicted grants left without an output packet");
  endtask

  task automatic check_rotation(input int n_packets);
    if (pkt_log.size() != n_packets)
      flag_error($sformatf("%0d packets out, expected %0d", pkt_log.size(), n_packets));
    for (int k = 0; k < pkt_log.size(); k++) begin
      if (pkt_log[k] != k % PORTS)
        flag_error($sformatf("packet %0d from port %0d, expected port %0d",
                             k, pkt_log[k], k % PORTS));
    end
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    test_err_base = errors;
    gen_count     = 0;
    pkt_log.delete();
    for (int i = 0; i < PORTS; i++) begin
      src_count[i] = 0;
      src_pos[i]   = 0;
    end
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors != test_err_base)
      tests_failed++;
    $display("test %-14s %s, %0d flits, %0d errors", test_name,
             (errors == test_err_base) ? "passed" : "failed", gen_count,
             errors - test_err_base);
  endtask

  initial begin : main
    i_reset = 1'b1;
    out_ready = 1'b1;
    for (int i = 0; i < PORTS; i++) begin
      in_valid[i]   = 1'b0;
      in_type[i]    = FLIT_HEAD;
      in_payload[i] = '0;
      src_seq[i]    = 0;
    end

    start_test("reset");
    apply_reset(1'b1);
    finish_test();

    start_test("single_source");
    load_packets(PORTS - 1, 12, 0);
    run_traffic(1'b0, 1'b0);
    for (int k = 0; k < pkt_log.size(); k++) begin
      if (pkt_log[k] != PORTS - 1)
        flag_error($sformatf("packet %0d from port %0d", k, pkt_log[k]));
    end
    finish_test();

    start_test("no_interleave");
    for (int i = 0; i < PORTS; i++)
      load_packets(i, 8, 0);
    run_traffic(1'b1, 1'b0);
    finish_test();

    // fresh pointer so the rotation starts at xp
    start_test("round_robin");
    apply_reset(1'b0);
    for (int i = 0; i < PORTS; i++)
      load_packets(i, 6, 0);
    run_traffic(1'b0, 1'b0);
    check_rotation(PORTS * 6);
    finish_test();

    start_test("back_pressure");
    for (int i = 0; i < PORTS; i++)
      load_packets(i, 8, 0);
    run_traffic(1'b1, 1'b1);
    finish_test();

    start_test("single_flit");
    for (int i = 0; i < PORTS; i++)
      load_packets(i, 10, 50);
    run_traffic(1'b0, 1'b1);
    finish_test();

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
source/noc_pkg.sv
source/flit_if.sv
source/port_control_if.sv
source/port_controller.sv
source/output_switch.sv
source/output_slice.sv
source/output_block.sv
dv/tb_output_block.sv

//--- source/flit_if.sv
`default_nettype none

interface flit_if import noc_pkg::*; ();

  logic                     valid;
  logic                     ready;
  flit_type_e               flit_type;
  logic [PAYLOAD_WIDTH-1:0] payload;

  // sender side holds valid, flit_type and payload until ready
  modport initiator (
    output valid,
    output flit_type,
    output payload,
    input  ready
  );

  modport target (
    input  valid,
    input  flit_type,
    input  payload,
    output ready
  );

endinterface

`default_nettype wire

//--- source/noc_pkg.sv
`default_nettype none

package noc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // router port geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // input sources in order xp, xm, yp, ym, l
  localparam int PORTS         = 5;
  localparam int PORT_ID_WIDTH = 3;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flit format
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int FLIT_TYPE_WIDTH = 2;
  // one word per flit
  localparam int PAYLOAD_WIDTH   = 16;

  typedef enum logic [FLIT_TYPE_WIDTH-1:0] {
    FLIT_HEAD      = 2'b00,
    FLIT_BODY      = 2'b01,
    FLIT_TAIL      = 2'b10,
    FLIT_HEAD_TAIL = 2'b11
  } flit_type_e;

  // head and head_tail open a packet
  function automatic logic is_packet_start(flit_type_e flit_type);
    return flit_type inside {FLIT_HEAD, FLIT_HEAD_TAIL};
  endfunction

  // tail and head_tail close a packet
  function automatic logic is_packet_end(flit_type_e flit_type);
    return flit_type inside {FLIT_TAIL, FLIT_HEAD_TAIL};
  endfunction

endpackage

`default_nettype wire

//--- source/output_block.sv
`default_nettype none

module output_block import noc_pkg::*; (
  input  logic                     clk,
  input  logic                     i_reset,
  // input sources, indexed xp, xm, yp, ym, l
  input  logic                     i_in_valid[PORTS],
  input  flit_type_e               i_in_flit_type[PORTS],
  input  logic [PAYLOAD_WIDTH-1:0] i_in_payload[PORTS],
  output logic                     o_in_ready[PORTS],
  // output link
  output logic                     o_out_valid,
  output flit_type_e               o_out_flit_type,
  output logic [PAYLOAD_WIDTH-1:0] o_out_payload,
  input  logic                     i_out_ready
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // internal links
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  flit_if         in_link[PORTS]();
  // switch to slice
  flit_if         switch_link();
  // slice to the output ports
  flit_if         out_link();
  port_control_if port_control();

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // plain ports onto the input links
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar i = 0; i < PORTS; i++) begin : g_input_port
    assign in_link[i].valid     = i_in_valid[i];
    assign in_link[i].flit_type = i_in_flit_type[i];
    assign in_link[i].payload   = i_in_payload[i];
    assign o_in_ready[i]        = in_link[i].ready;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // arbitration and switching
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  port_controller u_port_controller (
    .clk      (clk          ),
    .i_reset  (i_reset      ),
    .control  (port_control )
  );

  output_switch u_output_switch (
    .in_link  (in_link      ),
    .out_link (switch_link  ),
    .control  (port_control )
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // registered output stage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // breaks the ready path from the link back to the sources
  output_slice u_output_slice (
    .clk      (clk          ),
    .i_reset  (i_reset      ),
    .in_link  (switch_link  ),
    .out_link (out_link     )
  );

  assign o_out_valid     = out_link.valid;
  assign o_out_flit_type = out_link.flit_type;
  assign o_out_payload   = out_link.payload;
  assign out_link.ready  = i_out_ready;

endmodule

`default_nettype wire

//--- source/output_slice.sv
`default_nettype none

module output_slice import noc_pkg::*; (
  input  logic      clk,
  input  logic      i_reset,
  flit_if.target    in_link,
  flit_if.initiator out_link
);

  logic                     main_valid;
  flit_type_e               main_type;
  logic [PAYLOAD_WIDTH-1:0] main_payload;
  logic                     side_valid;
  flit_type_e               side_type;
  logic [PAYLOAD_WIDTH-1:0] side_payload;

  logic                     in_fire;
  logic                     main_load;

  // side entry only fills behind a stalled main entry
  assign in_link.ready = !side_valid;
  assign in_fire       = in_link.valid && in_link.ready;
  // main entry takes new data when empty or draining this cycle
  assign main_load     = !main_valid || out_link.ready;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      main_valid <= 1'b0;
      side_valid <= 1'b0;
    end else if (main_load) begin
      main_valid <= side_valid || in_fire;
      side_valid <= 1'b0;
    end else if (in_fire) begin
      side_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_load) begin
      if (side_valid) begin
        main_type    <= side_type;
        main_payload <= side_payload;
      end else begin
        main_type    <= in_link.flit_type;
        main_payload <= in_link.payload;
      end
    end
    if (!main_load && in_fire) begin
      side_type    <= in_link.flit_type;
      side_payload <= in_link.payload;
    end
  end

  assign out_link.valid     = main_valid;
  assign out_link.flit_type = main_type;
  assign out_link.payload   = main_payload;

endmodule

`default_nettype wire

//--- source/output_switch.sv
`default_nettype none

module output_switch import noc_pkg::*; (
  flit_if.target         in_link[PORTS],
  flit_if.initiator      out_link,
  port_control_if.switch control
);

  logic [PORTS-1:0]         in_valid;
  flit_type_e               in_type[PORTS];
  logic [PAYLOAD_WIDTH-1:0] in_payload[PORTS];
  logic [PORTS-1:0]         request;

  logic                     sel_valid;
  flit_type_e               sel_type;
  logic [PAYLOAD_WIDTH-1:0] sel_payload;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // per input unpacking and ready return
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar i = 0; i < PORTS; i++) begin : g_input
    assign in_valid[i]   = in_link[i].valid;
    assign in_type[i]    = in_link[i].flit_type;
    assign in_payload[i] = in_link[i].payload;

    // only a waiting head asks for the link
    assign request[i] = in_link[i].valid && is_packet_start(in_link[i].flit_type);

    assign in_link[i].ready = control.grant[i] && out_link.ready;
  end

  assign control.request = request;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flit mux
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // grant is one-hot, so at most one input is picked
  always_comb begin
    sel_valid   = 1'b0;
    sel_type    = FLIT_HEAD;
    sel_payload = '0;
    for (int i = 0; i < PORTS; i++) begin
      if (control.grant[i]) begin
        sel_valid   = in_valid[i];
        sel_type    = in_type[i];
        sel_payload = in_payload[i];
      end
    end
  end

  assign out_link.valid     = control.busy && sel_valid;
  assign out_link.flit_type = sel_type;
  assign out_link.payload   = sel_payload;

  // end of packet frees the link for the next head
  assign control.grant_release = out_link.valid && out_link.ready &&
                                 is_packet_end(sel_type);

endmodule

`default_nettype wire

//--- source/port_control_if.sv
`default_nettype none

interface port_control_if import noc_pkg::*; ();

  logic [PORTS-1:0] request;
  logic [PORTS-1:0] grant;
  logic             busy;
  // one cycle pulse when the end of packet flit transfers
  logic             grant_release;

  modport arbitrator (
    input  request,
    input  grant_release,
    output grant,
    output busy
  );

  modport switch (
    output request,
    output grant_release,
    input  grant,
    input  busy
  );

endinterface

`default_nettype wire

//--- source/port_controller.sv
`default_nettype none

module port_controller import noc_pkg::*; (
  input  logic               clk,
  input  logic               i_reset,
  port_control_if.arbitrator control
);

  logic [PORTS-1:0]         grant;
  logic                     busy;
  logic [PORT_ID_WIDTH-1:0] last_index;

  logic                     found;
  logic [PORT_ID_WIDTH-1:0] winner_index;
  logic [PORTS-1:0]         winner_onehot;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // round-robin search
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // walk from the farthest offset back to the nearest one, so the first
  // requester after the last granted port is the one that sticks
  always_comb begin : winner_search
    int candidate;
    found        = 1'b0;
    winner_index = last_index;
    for (int offset = PORTS; offset >= 1; offset--) begin
      candidate = (int'(last_index) + offset) % PORTS;
      if (control.request[candidate]) begin
        found        = 1'b1;
        winner_index = PORT_ID_WIDTH'(candidate);
      end
    end
  end

  always_comb begin
    winner_onehot               = '0;
    winner_onehot[winner_index] = 1'b1;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // grant state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // pointer starts on the last port so that port 0 is searched first
  always_ff @(posedge clk) begin
    if (i_reset) begin
      grant      <= '0;
      busy       <= 1'b0;
      last_index <= PORT_ID_WIDTH'(PORTS - 1);
    end else if (busy) begin
      // packet owns the link until its last flit leaves
      if (control.grant_release) begin
        grant <= '0;
        busy  <= 1'b0;
      end
    end else if (found) begin
      grant      <= winner_onehot;
      busy       <= 1'b1;
      last_index <= winner_index;
    end
  end

  assign control.grant = grant;
  assign control.busy  = busy;

endmodule

`default_nettype wire
